// File: Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --top-module clkgen_tb -f tb.f -Mdir obj_dir
	-./obj_dir/Vclkgen_tb 2>&1 | tee sim.log
	@if grep -q "CHECKS FAILED" sim.log; then exit 1; fi
	@grep -q "ALL CHECKS PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/clkgen_clock.sv
// Testbench clock and reset source
// 40 ns clkin, reset held high for the first 8 cycles
`timescale 1ns/1ps
`default_nettype none

module clkgen_clock (
  output logic clkin,
  output logic reset
);

  initial begin
    clkin = 1'b0;
    forever #20 clkin = ~clkin;                 // 40 ns period
  end

  initial begin
    reset = 1'b1;
    repeat (8) @(posedge clkin);
    reset <= 1'b0;                              // Release on a rising edge
  end

endmodule

`default_nettype wire

// File: bench/clkgen_tb.sv
// Clock generator testbench
// Table-driven checks of period, duty, quadrature lag and register readback
`timescale 1ns/1ps
`default_nettype none

module clkgen_tb
  import clkdiv_reg_pkg::*;
  import clkdiv_cfg_pkg::*;
();

  typedef struct {
    logic [3:0] code;
    logic       en;
    int         period;                         // clkin cycles with 1 for bypass and 0 held low
    int         high;                           // clkin cycles
    int         lag_half;                       // clkout90 lag in half clkin cycles
  } row_t;

  localparam int NROWS = 11;
  localparam real TCLK = 40.0;

  wire logic              clkin;
  wire logic              reset;
  logic                   cfg_write;
  reg_addr_t              cfg_addr;
  logic      [REG_DW-1:0] cfg_wdata;
  wire logic [REG_DW-1:0] cfg_rdata;
  wire logic              clkout;
  wire logic              clkout90;

  row_t   rows [NROWS];
  int     order [NROWS];
  int     cycles;                               // clkin cycles since start
  int     limit;                                // Timeout in clkin cycles
  integer seed;

  clkgen_clock i_clkgen_clock (
    .clkin (clkin),
    .reset (reset)
  );

  clkgen_top i_clkgen_top (
    .clkin     (clkin),
    .reset     (reset),
    .cfg_write (cfg_write),
    .cfg_addr  (cfg_addr),
    .cfg_wdata (cfg_wdata),
    .cfg_rdata (cfg_rdata),
    .clkout    (clkout),
    .clkout90  (clkout90)
  );

  // ####################
  // Failure handling
  // ####################

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("CHECKS FAILED");
    $fatal(1, "stopped at first error");
  endtask

  task automatic check_value(input string name, input int got, input int exp);
    assert (got == exp) else
      abort_run($sformatf("[FAIL] %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  // Watchdog on clkin cycles
  always @(posedge clkin) begin
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      $display("Timeout: clkout edges did not arrive within %0d cycles", limit);
      $display("CHECKS FAILED");
      $fatal(1, "timeout");
    end
  end

  // ####################
  // Register port
  // ####################

  task automatic write_reg(input reg_addr_t addr, input logic [REG_DW-1:0] data);
    @(posedge clkin);
    cfg_write <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(posedge clkin);
    cfg_write <= 1'b0;
  endtask

  task automatic read_check(input reg_addr_t addr, input logic [REG_DW-1:0] exp,
                            input string name);
    @(posedge clkin);
    cfg_addr <= addr;
    @(negedge clkin);                           // Read path settled mid-cycle
    check_value(name, int'(cfg_rdata), int'(exp));
  endtask

  // Poll until the staged code reaches the active register
  task automatic wait_active(input logic [3:0] code);
    int tries;
    tries = 0;
    @(posedge clkin);
    cfg_addr <= REG_ACTIVE;
    @(negedge clkin);
    while (cfg_rdata != {4'h0, code} && tries < 80) begin
      @(negedge clkin);
      tries++;
    end
    assert (tries < 80) else
      abort_run("REG_ACTIVE never took up the staged divide code");
  endtask

  // ####################
  // Measurements
  // ####################

  task automatic measure_divided(input row_t r);
    realtime t_rise;
    realtime t_q;
    realtime t_fall;
    realtime t_rise2;
    realtime t_q2;
    repeat (2) @(posedge clkout);               // Let the new code settle
    @(posedge clkout);
    t_rise = $realtime;
    @(posedge clkout90);
    t_q = $realtime;
    @(negedge clkout);
    t_fall = $realtime;
    @(posedge clkout);
    t_rise2 = $realtime;
    @(posedge clkout90);
    t_q2 = $realtime;
    check_value("clkout period", int'((t_rise2 - t_rise) / TCLK), r.period);
    check_value("clkout high", int'((t_fall - t_rise) / TCLK), r.high);
    check_value("clkout90 lag", int'((t_q - t_rise) / (TCLK / 2.0)), r.lag_half);
    check_value("clkout90 period", int'((t_q2 - t_q) / TCLK), r.period);
  endtask

  task automatic check_bypass();
    repeat (16) begin
      @(posedge clkin);
      #10;
      check_value("clkout", int'(clkout), 1);
      check_value("clkout90", int'(clkout90), 0);
      @(negedge clkin);
      #10;
      check_value("clkout", int'(clkout), 0);
      check_value("clkout90", int'(clkout90), 0);
    end
  endtask

  task automatic check_held_low();
    repeat (2) @(posedge clkin);                // Last divided edge drains
    repeat (64) begin
      @(posedge clkin);
      #10;
      check_value("clkout", int'(clkout), 0);
      check_value("clkout90", int'(clkout90), 0);
      @(negedge clkin);
      #10;
      check_value("clkout", int'(clkout), 0);
      check_value("clkout90", int'(clkout90), 0);
    end
  endtask

  task automatic apply_row(input row_t r);
    write_reg(REG_DIVCFG, {4'h0, r.code});
    write_reg(REG_ENABLE, {7'h0, r.en});
    read_check(REG_DIVCFG, {4'h0, r.code}, "cfg_rdata divcfg");
    read_check(REG_ENABLE, {7'h0, r.en}, "cfg_rdata enable");
    wait_active(r.code);
    if (r.period >= 2)
      measure_divided(r);
    else if (r.period == 1)
      check_bypass();
    else
      check_held_low();
  endtask

  // Code change in the middle of a period keeps every pulse full width
  task automatic check_midperiod_change();
    realtime t0;
    realtime t1;
    int      high;
    write_reg(REG_DIVCFG, {4'h0, 4'd4});        // Divide by 8
    write_reg(REG_ENABLE, 8'h01);
    wait_active(4'd4);
    @(posedge clkout);
    t0 = $realtime;
    write_reg(REG_DIVCFG, {4'h0, 4'd3});        // Divide by 4 while clkout is high
    repeat (5) begin
      @(negedge clkout);
      t1 = $realtime;
      high = int'((t1 - t0) / TCLK);
      assert (high == 4 || high == 2) else
        abort_run($sformatf("[FAIL] clkout high got 0x%0h expected 0x4 or 0x2", high));
      @(posedge clkout);
      t0 = $realtime;
    end
  endtask

  // ####################
  // Stimulus
  // ####################

  initial begin
    int j;
    int tmp;
    cfg_write = 1'b0;
    cfg_addr  = REG_DIVCFG;
    cfg_wdata = '0;
    cycles    = 0;
    limit     = 0;
    seed      = 32'h1d49ce8d;

    rows[0]  = '{4'd2,  1'b1, 2,  1,  1};       // N = 2 with falling-edge quadrature
    rows[1]  = '{4'd3,  1'b1, 4,  2,  2};
    rows[2]  = '{4'd4,  1'b1, 8,  4,  4};
    rows[3]  = '{4'd5,  1'b1, 16, 8,  8};
    rows[4]  = '{4'd6,  1'b1, 32, 16, 16};
    rows[5]  = '{4'd7,  1'b1, 64, 32, 32};
    rows[6]  = '{4'd1,  1'b1, 1,  0,  0};       // Bypass
    rows[7]  = '{4'd0,  1'b1, 0,  0,  0};       // Invalid codes
    rows[8]  = '{4'd8,  1'b1, 0,  0,  0};
    rows[9]  = '{4'd15, 1'b1, 0,  0,  0};
    rows[10] = '{4'd3,  1'b0, 0,  0,  0};       // Enable cleared

    // Both passes, the mid-period test and reset
    tmp = 6 * 8 + 200 + 8;
    for (int i = 0; i < NROWS; i++)
      tmp += 2 * (6 * rows[i].period + 200);
    limit = tmp;

    @(negedge reset);
    read_check(REG_ACTIVE, 8'h00, "cfg_rdata active after reset");
    check_value("clkout after reset", int'(clkout), 0);

    for (int i = 0; i < NROWS; i++)
      apply_row(rows[i]);

    // Second pass in shuffled order
    for (int i = 0; i < NROWS; i++)
      order[i] = i;
    for (int i = NROWS - 1; i > 0; i--) begin
      j = int'($unsigned($random(seed)) % (i + 1));
      tmp = order[i];
      order[i] = order[j];
      order[j] = tmp;
    end
    for (int i = 0; i < NROWS; i++)
      apply_row(rows[order[i]]);

    check_midperiod_change();

    $display("ALL CHECKS PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// File: design/clkdiv_cfg_pkg.sv
// Clock divider configuration package
// Divide-code encoding, counter width and terminal count decode
`default_nettype none

package clkdiv_cfg_pkg;

  // ####################
  // Divide encoding
  // ####################

  localparam int CNT_W = 8;                 // Period counter width

  typedef enum logic [3:0] {
    DIV_BYPASS = 4'd1,                      // clkin passed straight through
    DIV_2      = 4'd2,
    DIV_4      = 4'd3,
    DIV_8      = 4'd4,
    DIV_16     = 4'd5,
    DIV_32     = 4'd6,
    DIV_64     = 4'd7
  } div_code_t;                             // Any other value holds outputs low

  // Terminal count N for a code, zero means no edge ever matches
  function automatic logic [CNT_W-1:0] div_terminal(input div_code_t code);
    logic [CNT_W-1:0] n;
    case (code)
      DIV_2:   n = 8'd2;
      DIV_4:   n = 8'd4;
      DIV_8:   n = 8'd8;
      DIV_16:  n = 8'd16;
      DIV_32:  n = 8'd32;
      DIV_64:  n = 8'd64;
      default: n = '0;                      // Bypass and invalid codes
    endcase
    return n;
  endfunction

endpackage

`default_nettype wire

// File: design/clkdiv_reg_pkg.sv
// Clock divider register map package
// Host register addresses and field widths
`default_nettype none

package clkdiv_reg_pkg;

  // ####################
  // Register map
  // ####################

  localparam int REG_DW   = 8;              // Register port data width
  localparam int DIVCFG_W = 4;              // Divide code field, bits 3:0
  localparam int ENABLE_W = 1;              // Enable field, bit 0

  typedef enum logic [1:0] {
    REG_DIVCFG = 2'd0,                      // Staged divide code, read/write
    REG_ENABLE = 2'd1,                      // Staged enable, read/write
    REG_ACTIVE = 2'd2                       // Code in use by counter, read only
  } reg_addr_t;

endpackage

`default_nettype wire

// File: design/clkdiv_regs.sv
// Clock divider host registers
// Staged code and enable, copied to the active set on period boundaries
`timescale 1ns/1ps
`default_nettype none

module clkdiv_regs
  import clkdiv_reg_pkg::*;
  import clkdiv_cfg_pkg::*;
(
  input  wire logic              clkin,
  input  wire logic              reset,
  input  wire logic              cfg_write,     // One-cycle write strobe
  input  wire reg_addr_t         cfg_addr,
  input  wire logic [REG_DW-1:0] cfg_wdata,
  input  wire logic              boundary,      // Period boundary from counter
  output logic      [REG_DW-1:0] cfg_rdata,     // Combinational read
  output div_code_t              active_code,
  output logic                   run
);

  div_code_t             staged_code;           // Host-written divide code
  logic [ENABLE_W-1:0]   staged_run;            // Host-written enable

  // ####################
  // Staging registers
  // ####################

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      staged_code <= div_code_t'(4'd0);         // Invalid code, outputs low
      staged_run  <= '0;
    end else if (cfg_write) begin
      case (cfg_addr)
        REG_DIVCFG: staged_code <= div_code_t'(cfg_wdata[DIVCFG_W-1:0]);
        REG_ENABLE: staged_run  <= cfg_wdata[ENABLE_W-1:0];
        default:    ;                           // Active register is read only
      endcase
    end
  end

  // ####################
  // Active registers
  // ####################

  // Copy only at a boundary so a period is never cut short
  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      active_code <= div_code_t'(4'd0);
      run         <= 1'b0;
    end else if (boundary) begin
      active_code <= staged_code;
      run         <= staged_run[0];
    end
  end

  // ####################
  // Readback
  // ####################

  always_comb begin
    cfg_rdata = '0;                             // Unused bits read zero
    case (cfg_addr)
      REG_DIVCFG: cfg_rdata[DIVCFG_W-1:0] = staged_code;
      REG_ENABLE: cfg_rdata[ENABLE_W-1:0] = staged_run;
      REG_ACTIVE: cfg_rdata[DIVCFG_W-1:0] = active_code;  // Mirror of code in use
      default:    cfg_rdata = '0;
    endcase
  end

endmodule

`default_nettype wire

// File: design/clkgen_top.sv
// Serial link clock generator
// Register port, period counter and phase outputs
`timescale 1ns/1ps
`default_nettype none

module clkgen_top
  import clkdiv_reg_pkg::*;
  import clkdiv_cfg_pkg::*;
(
  input  wire logic              clkin,
  input  wire logic              reset,
  input  wire logic              cfg_write,
  input  wire reg_addr_t         cfg_addr,
  input  wire logic [REG_DW-1:0] cfg_wdata,
  output logic      [REG_DW-1:0] cfg_rdata,
  output logic                   clkout,
  output logic                   clkout90
);

  div_code_t active_code;                       // Code in use, boundary aligned
  logic      run;
  logic      boundary;

  divider_edge_if edge_link ();                 // Counter to output stage

  clkdiv_regs i_clkdiv_regs (
    .clkin       (clkin),
    .reset       (reset),
    .cfg_write   (cfg_write),
    .cfg_addr    (cfg_addr),
    .cfg_wdata   (cfg_wdata),
    .boundary    (boundary),
    .cfg_rdata   (cfg_rdata),
    .active_code (active_code),
    .run         (run)
  );

  divider_counter i_divider_counter (
    .clkin       (clkin),
    .reset       (reset),
    .active_code (active_code),
    .run         (run),
    .boundary    (boundary),
    .edges       (edge_link.counter)
  );

  phase_outputs i_phase_outputs (
    .clkin       (clkin),
    .reset       (reset),
    .edges       (edge_link.phase),
    .clkout      (clkout),
    .clkout90    (clkout90)
  );

endmodule

`default_nettype wire

// File: design/divider_counter.sv
// Clock divider period counter
// Self-resetting count with edge-match strobes for the output flops
`timescale 1ns/1ps
`default_nettype none

module divider_counter
  import clkdiv_cfg_pkg::*;
(
  input  wire logic       clkin,
  input  wire logic       reset,
  input  wire div_code_t  active_code,          // Changes only on a boundary
  input  wire logic       run,
  output logic            boundary,             // Safe point to switch code
  divider_edge_if.counter edges
);

  logic [CNT_W-1:0] term;                       // Terminal count N
  logic [CNT_W-1:0] half;                       // N/2
  logic [CNT_W-1:0] quarter;                    // N/4
  logic [CNT_W-1:0] count;
  logic             idle;                       // Stopped, bypass or invalid

  // ####################
  // Decode
  // ####################

  assign term    = div_terminal(active_code);
  assign half    = {1'b0, term[CNT_W-1:1]};
  assign quarter = {2'b00, term[CNT_W-1:2]};
  assign idle    = !run || (term == '0);

  // ####################
  // Period counter
  // ####################

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      count <= 8'd1;
    end else if (idle || edges.pos_match) begin
      count <= 8'd1;                            // Hold or start a new period
    end else begin
      count <= count + 8'd1;
    end
  end

  // ####################
  // Edge matching
  // ####################

  assign edges.pos_match   = !idle && (count == term);
  assign edges.neg_match   = !idle && (count == half);
  assign edges.pos90_match = !idle && (count == quarter);  // Never hits for N = 2
  assign edges.neg90_match = !idle && (count == quarter + half);

  // Mode reads as code 0 while stopped so the output stage holds low
  assign edges.mode = run ? active_code : div_code_t'(4'd0);

  // Idle keeps the boundary high so new settings land next cycle
  assign boundary = edges.pos_match || idle;

endmodule

`default_nettype wire

// File: design/divider_edge_if.sv
// Edge-match link from period counter to output stage
`timescale 1ns/1ps
`default_nettype none

interface divider_edge_if
  import clkdiv_cfg_pkg::*;
();

  logic      pos_match;                     // Count equals N
  logic      neg_match;                     // Count equals N/2
  logic      pos90_match;                   // Count equals N/4
  logic      neg90_match;                   // Count equals N/4 + N/2
  div_code_t mode;                          // Active code, zero when stopped

  modport counter (
    output pos_match, neg_match, pos90_match, neg90_match, mode
  );

  modport phase (
    input pos_match, neg_match, pos90_match, neg90_match, mode
  );

endinterface

`default_nettype wire

// File: design/phase_outputs.sv
// Clock divider output stage
// Aligned and 90-degree clock flops with bypass select
`timescale 1ns/1ps
`default_nettype none

module phase_outputs
  import clkdiv_cfg_pkg::*;
(
  input  wire logic     clkin,
  input  wire logic     reset,
  divider_edge_if.phase edges,
  output logic          clkout,                 // Aligned with clkin
  output logic          clkout90                // Lags clkout by a quarter period
);

  logic clkout_reg;
  logic clkout90_div4;                          // Rising-edge flop, N of 4 and up
  logic clkout90_div2;                          // Falling-edge flop, N = 2
  logic divided;                                // Mode is a valid divide code

  assign divided = (edges.mode >= DIV_2) && (edges.mode <= DIV_64);

  // ####################
  // Aligned clock
  // ####################

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      clkout_reg <= 1'b0;
    end else if (!divided) begin
      clkout_reg <= 1'b0;                       // Stopped, bypass or invalid
    end else if (edges.pos_match) begin
      clkout_reg <= 1'b1;
    end else if (edges.neg_match) begin
      clkout_reg <= 1'b0;
    end
  end

  // ####################
  // Quadrature clock
  // ####################

  always_ff @(posedge clkin or posedge reset) begin
    if (reset) begin
      clkout90_div4 <= 1'b0;
    end else if (!divided) begin
      clkout90_div4 <= 1'b0;
    end else if (edges.pos90_match) begin
      clkout90_div4 <= 1'b1;
    end else if (edges.neg90_match) begin
      clkout90_div4 <= 1'b0;
    end
  end

  // Half a clkin cycle behind clkout when dividing by 2
  always_ff @(negedge clkin or posedge reset) begin
    if (reset) begin
      clkout90_div2 <= 1'b0;
    end else if (!divided) begin
      clkout90_div2 <= 1'b0;
    end else if (edges.neg_match) begin
      clkout90_div2 <= 1'b1;
    end else if (edges.pos_match) begin
      clkout90_div2 <= 1'b0;
    end
  end

  assign clkout   = (edges.mode == DIV_BYPASS) ? clkin : clkout_reg;
  assign clkout90 = (edges.mode == DIV_2) ? clkout90_div2 : clkout90_div4;

endmodule

`default_nettype wire

// File: tb.f
design/clkdiv_cfg_pkg.sv
design/clkdiv_reg_pkg.sv
design/divider_edge_if.sv
design/clkdiv_regs.sv
design/divider_counter.sv
design/phase_outputs.sv
design/clkgen_top.sv
bench/clkgen_clock.sv
bench/clkgen_tb.sv
